/* src.f */
+incdir+hdl
hdl/cnnDataPkg.sv
hdl/cnnCtrlPkg.sv
hdl/paramMem.sv
hdl/memArbiter.sv
hdl/convPoolEngine.sv
hdl/denseLayer.sv
hdl/classSelect.sv
hdl/digitClassifier.sv
tb/digitClassifier_checker.sv
tb/tbDigitClassifier.sv

/* run.sh */
#!/bin/sh
# build and run the digit classifier testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f src.f \
    --top-module tbDigitClassifier \
    -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/VtbDigitClassifier
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0

/* tb/tbDigitClassifier.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cnn_cfg.svh"

module tbDigitClassifier
    import cnnDataPkg::*;
();

    localparam int NumRows    = 8;
    localparam int CycleLimit = NumRows * 3000;

    // pixel fill modes
    localparam int PixZero     = 0;
    localparam int PixRandom   = 1;
    localparam int PixNegative = 2;
    localparam int PixMax      = 3;

    // weight fill modes for kernel and FC alike
    localparam int WgtRandom   = 0;
    localparam int WgtPositive = 1;
    localparam int WgtFixed    = 2;

    logic      clk;
    logic      rst;
    logic      start;
    logic      wrEn;
    memAddr_t  wrAddr;
    pixel_t    wrData;
    logic      busy;
    logic      done;
    classIdx_t classIdx;
    score_t    bestScore;

    string rowName      [NumRows];
    int    rowPix       [NumRows];
    int    rowWgt       [NumRows];
    bit    rowBusyWrite [NumRows];
    bit    rowHasExp    [NumRows];
    int    rowExpClass  [NumRows];
    int    rowExpScore  [NumRows];

    // what the memory should hold
    pixel_t shadow [`MEM_DEPTH];
    int     seed;
    int     cycleCount = 0;
    int     expClass;
    int     expScore;

    digitClassifier u_dut (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .wrEn      (wrEn),
        .wrAddr    (wrAddr),
        .wrData    (wrData),
        .busy      (busy),
        .done      (done),
        .classIdx  (classIdx),
        .bestScore (bestScore)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == CycleLimit) begin
            $display("test failed");
            $fatal(1, "timeout, no result within %0d cycles", CycleLimit);
        end
    end

    task automatic checkValue(input string testName, input string what,
                              input int expected, input int actual);
        if (expected != actual) begin
            $display("Fail %s %s: expected %0d, actual %0d",
                     testName, what, expected, actual);
            $display("test failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    function automatic void setRow(input int idx, input string name,
                                   input int pix, input int wgt, input bit busyWr,
                                   input bit hasExp, input int expCls, input int expScr);
        rowName[idx]      = name;
        rowPix[idx]       = pix;
        rowWgt[idx]       = wgt;
        rowBusyWrite[idx] = busyWr;
        rowHasExp[idx]    = hasExp;
        rowExpClass[idx]  = expCls;
        rowExpScore[idx]  = expScr;
    endfunction

    // name, pixels, weights, writes while busy, fixed result known, class, score
    task automatic buildTable();
        setRow(0, "zero_image",     PixZero,     WgtRandom,   1'b0, 1'b1, 0, 0);
        setRow(1, "random_image",   PixRandom,   WgtRandom,   1'b0, 1'b0, 0, 0);
        setRow(2, "negative_image", PixNegative, WgtPositive, 1'b0, 1'b1, 0, 0);
        setRow(3, "max_image",      PixMax,      WgtPositive, 1'b0, 1'b0, 0, 0);
        setRow(4, "busy_writes",    PixRandom,   WgtFixed,    1'b1, 1'b0, 0, 0);
        setRow(5, "random_again",   PixRandom,   WgtRandom,   1'b0, 1'b0, 0, 0);
        setRow(6, "max_fixed",      PixMax,      WgtFixed,    1'b0, 1'b0, 0, 0);
        setRow(7, "random_last",    PixRandom,   WgtRandom,   1'b1, 1'b0, 0, 0);
    endtask

    task automatic fillShadow(input int row);
        for (int a = 0; a < `MEM_DEPTH; a++) begin
            if (a < `KER_BASE) begin
                case (rowPix[row])
                    PixZero:     shadow[a] = '0;
                    PixRandom:   shadow[a] = pixel_t'($random(seed));
                    PixNegative: shadow[a] = pixel_t'(-1 - ($random(seed) & 127));
                    default:     shadow[a] = pixel_t'(127);
                endcase
            end else begin
                case (rowWgt[row])
                    WgtRandom:   shadow[a] = pixel_t'($random(seed));
                    WgtPositive: shadow[a] = pixel_t'(16 + ($random(seed) & 63));
                    default:     shadow[a] = pixel_t'(a * 37 + 5);
                endcase
            end
        end
    endtask

    // reference model of conv, 2x2 max pool, clamp and shift, FC and argmax
    task automatic predict();
        int feat  [`NUM_FEAT];
        int total [`NUM_CLASS];
        int sum;
        int poolBest;
        int row;
        int col;
        int f;
        int q;
        f = 0;
        for (int pr = 0; pr < `POOL_DIM; pr++) begin
            for (int pc = 0; pc < `POOL_DIM; pc++) begin
                poolBest = 0;
                for (int w = 0; w < 4; w++) begin
                    row = 2 * pr + w / 2;
                    col = 2 * pc + w % 2;
                    sum = 0;
                    for (int kr = 0; kr < `KER_DIM; kr++) begin
                        for (int kc = 0; kc < `KER_DIM; kc++) begin
                            sum += int'(shadow[`PIX_BASE + (row + kr) * `IMG_DIM + col + kc])
                                 * int'(shadow[`KER_BASE + kr * `KER_DIM + kc]);
                        end
                    end
                    if (w == 0 || sum > poolBest) begin
                        poolBest = sum;
                    end
                end
                q = (poolBest < 0) ? 0 : (poolBest >> `QUANT_SHIFT);
                feat[f] = (q > `FEAT_MAX) ? `FEAT_MAX : q;
                f++;
            end
        end
        for (int c = 0; c < `NUM_CLASS; c++) begin
            total[c] = 0;
            for (int i = 0; i < `NUM_FEAT; i++) begin
                total[c] += feat[i] * int'(shadow[`FC_BASE + i * `NUM_CLASS + c]);
            end
        end
        expClass = 0;
        expScore = total[0];
        for (int c = 1; c < `NUM_CLASS; c++) begin
            if (total[c] > expScore) begin
                expClass = c;
                expScore = total[c];
            end
        end
    endtask

    task automatic loadMemory();
        for (int a = 0; a < `MEM_DEPTH; a++) begin
            @(negedge clk);
            wrEn   = 1'b1;
            wrAddr = memAddr_t'(a);
            wrData = shadow[a];
        end
        @(negedge clk);
        wrEn = 1'b0;
    endtask

    // these writes must not reach the memory
    task automatic writeWhileBusy(input string testName);
        for (int a = 0; a < `MEM_DEPTH; a++) begin
            @(negedge clk);
            checkValue(testName, "busy during write", 1, int'(busy));
            wrEn   = 1'b1;
            wrAddr = memAddr_t'(a);
            wrData = ~shadow[a];
        end
        @(negedge clk);
        wrEn = 1'b0;
    endtask

    task automatic startRun(input string testName);
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        checkValue(testName, "busy after start", 1, int'(busy));
    endtask

    task automatic waitDone();
        @(negedge clk);
        while (!done) begin
            @(negedge clk);
        end
    endtask

    task automatic checkResult(input int row);
        checkValue(rowName[row], "class", expClass, int'(classIdx));
        checkValue(rowName[row], "score", expScore, int'(bestScore));
        if (rowHasExp[row]) begin
            checkValue(rowName[row], "table class", rowExpClass[row], int'(classIdx));
            checkValue(rowName[row], "table score", rowExpScore[row], int'(bestScore));
        end
    endtask

    initial begin
        seed       = 32'h6c8b_3df7;
        rst        = 1'b0;
        start      = 1'b0;
        wrEn       = 1'b0;
        wrAddr     = '0;
        wrData     = '0;
        buildTable();
        repeat (8) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        checkValue("reset", "busy", 0, int'(busy));
        checkValue("reset", "done", 0, int'(done));
        for (int r = 0; r < NumRows; r++) begin
            fillShadow(r);
            predict();
            loadMemory();
            startRun(rowName[r]);
            if (rowBusyWrite[r]) begin
                writeWhileBusy(rowName[r]);
            end
            waitDone();
            checkResult(r);
            // rerun on the untouched contents
            if (rowBusyWrite[r]) begin
                startRun(rowName[r]);
                waitDone();
                checkResult(r);
            end
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/digitClassifier_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module digitClassifier_checker (
    input logic clk,
    input logic rst,
    input logic busy,
    input logic done,
    input logic convGrant,
    input logic denseGrant,
    input logic featValid,
    input logic denseReq,
    input logic denseDataValid
);

    // one owner of the read port per cycle
    grantsExclusive: assert property (@(posedge clk) disable iff (!rst)
        !(convGrant && denseGrant))
        else $error("conv and dense grants high in the same cycle");

    donePulse: assert property (@(posedge clk) disable iff (!rst)
        done |=> !done)
        else $error("done high for more than one cycle");

    // dense layer must be back in idle before the next feature
    featureWhileIdle: assert property (@(posedge clk) disable iff (!rst)
        featValid |-> !(denseReq || denseDataValid))
        else $error("feature arrived while the dense layer was busy");

    doneWithBusy: assert property (@(posedge clk) disable iff (!rst)
        done |-> busy)
        else $error("done raised while busy was low");

endmodule

bind digitClassifier digitClassifier_checker u_checker (
    .clk            (clk),
    .rst            (rst),
    .busy           (busy),
    .done           (done),
    .convGrant      (convGrant),
    .denseGrant     (denseGrant),
    .featValid      (featValid),
    .denseReq       (denseReq),
    .denseDataValid (denseDataValid)
);

`default_nettype wire

/* hdl/digitClassifier.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cnn_cfg.svh"

module digitClassifier
    import cnnDataPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  logic      wrEn,
    input  memAddr_t  wrAddr,
    input  pixel_t    wrData,
    output logic      busy,
    output logic      done,
    output classIdx_t classIdx,
    output score_t    bestScore
);

    logic     accept;
    logic     memWrEn;
    memAddr_t memAddr;
    pixel_t   memData;
    logic     convReq;
    logic     convGrant;
    logic     convDataValid;
    logic     convRunning;
    memAddr_t convAddr;
    pixel_t   convData;
    logic     denseReq;
    logic     denseGrant;
    logic     denseDataValid;
    memAddr_t denseAddr;
    pixel_t   denseData;
    logic     featValid;
    feature_t featData;
    logic     scoresValid;
    score_t   scores [`NUM_CLASS];

    // host access only while idle
    assign accept  = start && !busy && !convRunning;
    assign memWrEn = wrEn && !busy;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    paramMem u_mem (
        .clk    (clk),
        .wrEn   (memWrEn),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .rdAddr (memAddr),
        .rdData (memData)
    );

    memArbiter u_arb (
        .clk            (clk),
        .rst            (rst),
        .convReq        (convReq),
        .denseReq       (denseReq),
        .convAddr       (convAddr),
        .denseAddr      (denseAddr),
        .convGrant      (convGrant),
        .denseGrant     (denseGrant),
        .memAddr        (memAddr),
        .memData        (memData),
        .convDataValid  (convDataValid),
        .denseDataValid (denseDataValid),
        .convData       (convData),
        .denseData      (denseData)
    );

    convPoolEngine u_conv (
        .clk       (clk),
        .rst       (rst),
        .start     (accept),
        .req       (convReq),
        .addr      (convAddr),
        .grant     (convGrant),
        .dataValid (convDataValid),
        .data      (convData),
        .featValid (featValid),
        .featData  (featData),
        .running   (convRunning)
    );

    denseLayer u_dense (
        .clk         (clk),
        .rst         (rst),
        .start       (accept),
        .featValid   (featValid),
        .featData    (featData),
        .req         (denseReq),
        .addr        (denseAddr),
        .grant       (denseGrant),
        .dataValid   (denseDataValid),
        .data        (denseData),
        .scoresValid (scoresValid),
        .scores      (scores)
    );

    classSelect u_sel (
        .clk         (clk),
        .rst         (rst),
        .scoresValid (scoresValid),
        .scores      (scores),
        .done        (done),
        .classIdx    (classIdx),
        .bestScore   (bestScore)
    );

endmodule

`default_nettype wire

/* hdl/classSelect.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cnn_cfg.svh"

module classSelect
    import cnnDataPkg::*;
    import cnnCtrlPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      scoresValid,
    input  score_t    scores [`NUM_CLASS],
    output logic      done,
    output classIdx_t classIdx,
    output score_t    bestScore
);

    selState_t state;
    classIdx_t cmpIdx;
    classIdx_t bestIdx;
    score_t    best;
    score_t    latched [`NUM_CLASS];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state  <= SelIdle;
            cmpIdx <= '0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                SelIdle: begin
                    if (scoresValid) begin
                        cmpIdx <= 2'd1;
                        state  <= SelCompare;
                    end
                end
                SelCompare: begin
                    cmpIdx <= cmpIdx + 2'd1;
                    if (cmpIdx == 2'(`NUM_CLASS - 1)) begin
                        state <= SelReport;
                    end
                end
                SelReport: begin
                    done  <= 1'b1;
                    state <= SelIdle;
                end
                default: begin
                    state <= SelIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == SelIdle && scoresValid) begin
            latched <= scores;
            best    <= scores[0];
            bestIdx <= '0;
        end else if (state == SelCompare && latched[cmpIdx] > best) begin
            // ties stay with the lower index
            best    <= latched[cmpIdx];
            bestIdx <= cmpIdx;
        end
        if (state == SelReport) begin
            classIdx  <= bestIdx;
            bestScore <= best;
        end
    end

endmodule

`default_nettype wire

/* hdl/denseLayer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cnn_cfg.svh"

module denseLayer
    import cnnDataPkg::*;
    import cnnCtrlPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  logic     featValid,
    input  feature_t featData,
    output logic     req,
    output memAddr_t addr,
    input  logic     grant,
    input  logic     dataValid,
    input  pixel_t   data,
    output logic     scoresValid,
    output score_t   scores [`NUM_CLASS]
);

    denseState_t state;
    feature_t    featReg;
    logic [3:0]  featCnt;
    classIdx_t   cls;
    logic signed [15:0] product;

    assign req     = (state == DenseFetchWeight);
    assign addr    = memAddr_t'(`FC_BASE + featCnt * `NUM_CLASS + cls);
    // feature is unsigned, widen with a zero sign bit
    assign product = signed'({1'b0, featReg}) * data;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state       <= DenseIdle;
            featCnt     <= '0;
            cls         <= '0;
            scoresValid <= 1'b0;
        end else begin
            scoresValid <= 1'b0;
            case (state)
                DenseIdle: begin
                    if (start) begin
                        featCnt <= '0;
                    end else if (featValid) begin
                        cls   <= '0;
                        state <= DenseFetchWeight;
                    end
                end
                DenseFetchWeight: begin
                    if (grant) begin
                        state <= DenseAccumulate;
                    end
                end
                DenseAccumulate: begin
                    if (dataValid) begin
                        if (cls == 2'(`NUM_CLASS - 1)) begin
                            cls   <= '0;
                            state <= DenseIdle;
                            if (featCnt == 4'(`NUM_FEAT - 1)) begin
                                featCnt     <= '0;
                                scoresValid <= 1'b1;
                            end else begin
                                featCnt <= featCnt + 4'd1;
                            end
                        end else begin
                            cls   <= cls + 2'd1;
                            state <= DenseFetchWeight;
                        end
                    end
                end
                default: begin
                    state <= DenseIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            for (int c = 0; c < `NUM_CLASS; c++) begin
                scores[c] <= '0;
            end
        end else if (state == DenseAccumulate && dataValid) begin
            scores[cls] <= scores[cls] + score_t'(product);
        end
        if (state == DenseIdle && featValid) begin
            featReg <= featData;
        end
    end

endmodule

`default_nettype wire

/* hdl/convPoolEngine.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cnn_cfg.svh"

module convPoolEngine
    import cnnDataPkg::*;
    import cnnCtrlPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    output logic     req,
    output memAddr_t addr,
    input  logic     grant,
    input  logic     dataValid,
    input  pixel_t   data,
    output logic     featValid,
    output feature_t featData,
    output logic     running
);

    convState_t state;
    logic [1:0] poolRow;
    logic [1:0] poolCol;
    logic [1:0] winIdx;
    logic [1:0] tapRow;
    logic [1:0] tapCol;
    logic [3:0] featCnt;
    logic [2:0] convRow;
    logic [2:0] convCol;
    memAddr_t   pixAddr;
    memAddr_t   kerAddr;
    pixel_t     pixReg;
    logic signed [15:0] product;
    convSum_t   acc;
    convSum_t   poolMax;
    convSum_t   shifted;

    // conv output position of the current sub-window
    assign convRow = {poolRow, winIdx[1]};
    assign convCol = {poolCol, winIdx[0]};

    assign pixAddr = memAddr_t'(`PIX_BASE + (convRow + tapRow) * `IMG_DIM + convCol + tapCol);
    assign kerAddr = memAddr_t'(`KER_BASE + tapRow * `KER_DIM + tapCol);

    assign req     = (state == ConvFetchPixel) || (state == ConvFetchWeight);
    assign addr    = (state == ConvFetchPixel) ? pixAddr : kerAddr;
    assign running = (state != ConvIdle);
    assign product = pixReg * data;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state   <= ConvIdle;
            poolRow <= '0;
            poolCol <= '0;
            winIdx  <= '0;
            tapRow  <= '0;
            tapCol  <= '0;
            featCnt <= '0;
        end else begin
            case (state)
                ConvIdle: begin
                    if (start) begin
                        poolRow <= '0;
                        poolCol <= '0;
                        winIdx  <= '0;
                        tapRow  <= '0;
                        tapCol  <= '0;
                        featCnt <= '0;
                        state   <= ConvFetchPixel;
                    end
                end
                ConvFetchPixel: begin
                    if (grant) begin
                        state <= ConvFetchWeight;
                    end
                end
                ConvFetchWeight: begin
                    if (grant) begin
                        state <= ConvAccumulate;
                    end
                end
                ConvAccumulate: begin
                    if (dataValid) begin
                        if (tapCol == 2'(`KER_DIM - 1)) begin
                            tapCol <= '0;
                            if (tapRow == 2'(`KER_DIM - 1)) begin
                                tapRow <= '0;
                                state  <= ConvPoolUpdate;
                            end else begin
                                tapRow <= tapRow + 2'd1;
                                state  <= ConvFetchPixel;
                            end
                        end else begin
                            tapCol <= tapCol + 2'd1;
                            state  <= ConvFetchPixel;
                        end
                    end
                end
                ConvPoolUpdate: begin
                    // four sub-windows per pooled window, wraps to 0
                    winIdx <= winIdx + 2'd1;
                    state  <= (winIdx == 2'd3) ? ConvEmit : ConvFetchPixel;
                end
                ConvEmit: begin
                    if (featCnt == 4'(`NUM_FEAT - 1)) begin
                        state <= ConvFinish;
                    end else begin
                        featCnt <= featCnt + 4'd1;
                        if (poolCol == 2'(`POOL_DIM - 1)) begin
                            poolCol <= '0;
                            poolRow <= poolRow + 2'd1;
                        end else begin
                            poolCol <= poolCol + 2'd1;
                        end
                        state <= ConvFetchPixel;
                    end
                end
                ConvFinish: begin
                    state <= ConvIdle;
                end
                default: begin
                    state <= ConvIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ConvFetchWeight && dataValid) begin
            pixReg <= data;
        end
        if (state == ConvIdle && start) begin
            acc <= '0;
        end else if (state == ConvAccumulate && dataValid) begin
            acc <= acc + convSum_t'(product);
        end else if (state == ConvPoolUpdate) begin
            acc <= '0;
            // strict compare so the earlier sum keeps a tie
            if (winIdx == 2'd0 || acc > poolMax) begin
                poolMax <= acc;
            end
        end
    end

    // clamp negatives, shift, saturate
    assign shifted   = poolMax >>> `QUANT_SHIFT;
    assign featValid = (state == ConvEmit);

    always_comb begin
        if (poolMax < 0) begin
            featData = '0;
        end else if (shifted > convSum_t'(`FEAT_MAX)) begin
            featData = feature_t'(`FEAT_MAX);
        end else begin
            featData = shifted[6:0];
        end
    end

endmodule

`default_nettype wire

/* hdl/memArbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module memArbiter
    import cnnDataPkg::*;
    import cnnCtrlPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     convReq,
    input  logic     denseReq,
    input  memAddr_t convAddr,
    input  memAddr_t denseAddr,
    output logic     convGrant,
    output logic     denseGrant,
    output memAddr_t memAddr,
    input  pixel_t   memData,
    output logic     convDataValid,
    output logic     denseDataValid,
    output pixel_t   convData,
    output pixel_t   denseData
);

    requester_t lastGrant;

    // dense layer wins over the conv engine
    assign denseGrant = denseReq;
    assign convGrant  = convReq && !denseReq;
    assign memAddr    = denseGrant ? denseAddr : convAddr;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lastGrant <= ReqNone;
        end else if (denseGrant) begin
            lastGrant <= ReqDense;
        end else if (convGrant) begin
            lastGrant <= ReqConv;
        end else begin
            lastGrant <= ReqNone;
        end
    end

    // steer read data back to whoever held the port
    assign convDataValid  = (lastGrant == ReqConv);
    assign denseDataValid = (lastGrant == ReqDense);
    assign convData       = convDataValid ? memData : '0;
    assign denseData      = denseDataValid ? memData : '0;

endmodule

`default_nettype wire

/* hdl/paramMem.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cnn_cfg.svh"

module paramMem
    import cnnDataPkg::*;
(
    input  logic     clk,
    input  logic     wrEn,
    input  memAddr_t wrAddr,
    input  pixel_t   wrData,
    input  memAddr_t rdAddr,
    output pixel_t   rdData
);

    // pixels, kernel taps and FC weights in one array
    pixel_t mem [`MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        rdData <= mem[rdAddr];
    end

endmodule

`default_nettype wire

/* hdl/cnnCtrlPkg.sv */
`default_nettype none

package cnnCtrlPkg;

    typedef enum logic [2:0] {
        ConvIdle,
        ConvFetchPixel,
        ConvFetchWeight,
        ConvAccumulate,
        ConvPoolUpdate,
        ConvEmit,
        ConvFinish
    } convState_t;

    typedef enum logic [1:0] {
        DenseIdle,
        DenseFetchWeight,
        DenseAccumulate
    } denseState_t;

    typedef enum logic [1:0] {
        SelIdle,
        SelCompare,
        SelReport
    } selState_t;

    // owner of the read port in the previous cycle
    typedef enum logic [1:0] {
        ReqNone,
        ReqConv,
        ReqDense
    } requester_t;

endpackage

`default_nettype wire

/* hdl/cnnDataPkg.sv */
`default_nettype none

`include "cnn_cfg.svh"

package cnnDataPkg;

    // pixels and weights share one format
    typedef logic signed [7:0] pixel_t;

    // convolution or pooled value
    typedef logic signed [19:0] convSum_t;

    // quantized feature, never negative
    typedef logic [6:0] feature_t;

    typedef logic signed [19:0] score_t;

    typedef logic [1:0] classIdx_t;

    typedef logic [`ADDR_W-1:0] memAddr_t;

endpackage

`default_nettype wire

/* hdl/cnn_cfg.svh */
`ifndef CNN_CFG_SVH
`define CNN_CFG_SVH

// image and kernel geometry
`define IMG_DIM     8
`define KER_DIM     3
`define CONV_DIM    6
`define POOL_DIM    3
`define NUM_FEAT    9
`define NUM_CLASS   4

// quantization of pooled sums
`define QUANT_SHIFT 4
`define FEAT_MAX    127

// parameter memory map
`define ADDR_W      7
`define PIX_BASE    0
`define KER_BASE    64
`define FC_BASE     73
`define MEM_DEPTH   109

`endif
